// ==== step_motor_ctrl_top.f ====
rtl/step_motor_pkg.sv
rtl/speed_table_ram.sv
rtl/step_clk_divider.sv
rtl/motor_ramp_core.sv
rtl/motor_regs_axil.sv
rtl/step_motor_ctrl_top.sv
verification/step_motor_properties.sv
verification/step_motor_tb.sv

// ==== verification/step_motor_tb.sv ====
`timescale 1ns/1ps

module step_motor_tb
	import step_motor_pkg::*;
();

	localparam int REVERSE_DELAY = 4;
	localparam int TOTAL_STEPS = 12 + 200 + 6 + 20 + 60;
	// slowest step is two levels of 7 ticks, 8 clocks per tick
	localparam int STEP_NS_MAX = 2 * 7 * 8 * 100;
	localparam int WATCHDOG_NS = TOTAL_STEPS * STEP_NS_MAX + 500000;

	logic clk;
	logic resetn;
	logic [AXI_ADDR_W-1:0] awaddr;
	logic awvalid;
	logic awready;
	logic [31:0] wdata;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [AXI_ADDR_W-1:0] araddr;
	logic arvalid;
	logic arready;
	logic [31:0] rdata;
	logic [1:0] rresp;
	logic rvalid;
	logic rready;
	logic zpd;
	logic drive;
	logic dir;
	logic [MS_W-1:0] ms;

	integer seed;
	int acce_tbl [0:15];
	int deac_tbl [0:15];
	int acce_max_v;
	int deac_max_v;
	int cmd_speed;
	int prof_n;
	logic prof_on;
	int clk_div;
	int stroke_val;
	int rise_count;
	int clk_cnt;
	int clk_total;
	int first_rise_clk;
	int model_pos;
	logic drive_prev;
	int errors;
	int checks;
	int tests;
	int test_err0;

	step_motor_ctrl_top #(
		.SPEED_ADDR_W(8),
		.REVERSE_DELAY(REVERSE_DELAY)
	) i_step_motor_ctrl_top (
		.clk(clk),
		.resetn(resetn),
		.i_s_axil_awaddr(awaddr),
		.i_s_axil_awvalid(awvalid),
		.o_s_axil_awready(awready),
		.i_s_axil_wdata(wdata),
		.i_s_axil_wvalid(wvalid),
		.o_s_axil_wready(wready),
		.o_s_axil_bresp(bresp),
		.o_s_axil_bvalid(bvalid),
		.i_s_axil_bready(bready),
		.i_s_axil_araddr(araddr),
		.i_s_axil_arvalid(arvalid),
		.o_s_axil_arready(arready),
		.o_s_axil_rdata(rdata),
		.o_s_axil_rresp(rresp),
		.o_s_axil_rvalid(rvalid),
		.i_s_axil_rready(rready),
		.i_zpd(zpd),
		.o_drive(drive),
		.o_dir(dir),
		.o_ms(ms)
	);

	always #50 clk = ~clk;

	// expected half-period of step k in an n-step move
	function automatic int ref_speed(input int amax, input int dmax, input int cmd,
		input int n, input int k);
		int ia;
		int id;
		int s;
		ia = (k < amax) ? k : amax;
		id = (n - 1 - k < dmax) ? n - 1 - k : dmax;
		s = (acce_tbl[ia] > deac_tbl[id]) ? acce_tbl[ia] : deac_tbl[id];
		if (cmd > s)
			s = cmd;
		return s;
	endfunction

	task automatic check_eq(input string what, input int got, input int exp);
		checks = checks + 1;
		if (got != exp) begin
			errors = errors + 1;
			$display("Error %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic check_level(input int k, input int ticks);
		int exp_s;
		exp_s = ref_speed(acce_max_v, deac_max_v, cmd_speed, prof_n, k);
		checks = checks + 1;
		if (ticks != exp_s + 1) begin
			errors = errors + 1;
			$display("Error %0t ns: step %0d level lasted %0d ticks, expected %0d",
				$time, k, ticks, exp_s + 1);
		end
	endtask

	// level lengths, rising edge count and a position model for the sensor
	always @(posedge clk) begin
		int ticks;
		if (!resetn) begin
			clk_cnt = 0;
			drive_prev = 1'b0;
		end else begin
			clk_total <= clk_total + 1;
			clk_cnt = clk_cnt + 1;
			if (drive != drive_prev) begin
				ticks = clk_cnt / (clk_div + 1);
				if (drive) begin
					if (prof_on && rise_count > 0)
						check_level(rise_count - 1, ticks);
					if (rise_count == 0)
						first_rise_clk = clk_total;
					rise_count = rise_count + 1;
				end else begin
					if (prof_on)
						check_level(rise_count - 1, ticks);
					if (!dir && model_pos < stroke_val)
						model_pos = model_pos + 1;
					else if (dir && model_pos > 1)
						model_pos = model_pos - 1;
				end
				clk_cnt = 0;
				drive_prev = drive;
			end
			// sensor sits at position 1
			zpd <= (model_pos == 1) && dir;
		end
	end

	task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
		output logic [1:0] resp);
		int n;
		@(posedge clk);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		bready <= 1'b1;
		n = 0;
		@(posedge clk);
		while (!(awready && wready) && n < 50) begin
			@(posedge clk);
			n = n + 1;
		end
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		@(posedge clk);
		while (!bvalid && n < 50) begin
			@(posedge clk);
			n = n + 1;
		end
		resp = bresp;
		bready <= 1'b0;
		if (n >= 50) begin
			errors = errors + 1;
			$display("AXI write to %h got no response", addr);
		end
	endtask

	task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int n;
		@(posedge clk);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		n = 0;
		@(posedge clk);
		while (!arready && n < 50) begin
			@(posedge clk);
			n = n + 1;
		end
		arvalid <= 1'b0;
		@(posedge clk);
		while (!rvalid && n < 50) begin
			@(posedge clk);
			n = n + 1;
		end
		data = rdata;
		resp = rresp;
		rready <= 1'b0;
		if (n >= 50) begin
			errors = errors + 1;
			$display("AXI read from %h got no response", addr);
		end
	endtask

	task automatic reg_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [1:0] resp;
		axi_write(addr, data, resp);
		check_eq("bresp", resp, 0);
	endtask

	task automatic reg_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data);
		logic [1:0] resp;
		axi_read(addr, data, resp);
		check_eq("rresp", resp, 0);
	endtask

	task automatic write_readback(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		reg_write(addr, data);
		reg_read(addr, rd);
		checks = checks + 1;
		if (rd != data) begin
			errors = errors + 1;
			$display("Error %0t ns: register %h reads %h, wrote %h", $time, addr, rd, data);
		end
	endtask

	task automatic start_move(input int n, input logic mdir, input logic [MS_W-1:0] mstep,
		input logic check_prof);
		prof_n = n;
		prof_on = check_prof;
		rise_count = 0;
		reg_write(REG_STEPS, n);
		reg_write(REG_CTRL, {25'd0, mstep, 1'b0, mdir, 2'b01});
	endtask

	task automatic wait_rises(input int n);
		int c;
		c = 0;
		while (rise_count < n && c < 5000) begin
			@(posedge clk);
			c = c + 1;
		end
		if (rise_count < n) begin
			errors = errors + 1;
			$display("drive gave only %0d of %0d rising edges", rise_count, n);
		end
	endtask

	// the start is consumed within one tick, so running shows up first
	task automatic wait_idle(input logic need_start);
		logic [31:0] st;
		int n;
		st = '0;
		n = 0;
		if (!need_start)
			st[0] = 1'b1;
		while (!st[0] && n < 20) begin
			reg_read(REG_STATUS, st);
			n = n + 1;
		end
		if (!st[0]) begin
			errors = errors + 1;
			$display("move never started");
		end
		n = 0;
		while (st[0] && n < 4000) begin
			reg_read(REG_STATUS, st);
			n = n + 1;
		end
		if (st[0]) begin
			errors = errors + 1;
			$display("move did not end in time");
		end
	endtask

	task automatic begin_test();
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		tests = tests + 1;
		if (errors == test_err0)
			$display("test %0d %s: ok", tests, name);
		else
			$display("test %0d %s: %0d errors", tests, name, errors - test_err0);
	endtask

	initial begin
		#WATCHDOG_NS;
		$display("watchdog expired, the run did not finish in time");
		$display("Done: errors found");
		$finish;
	end

	initial begin
		logic [31:0] rd;
		logic [1:0] resp;
		int i;
		int pos0;
		int t0;
		logic dir0;
		clk = 1'b0;
		resetn = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		zpd = 1'b0;
		seed = 32'h8b78308f;
		errors = 0;
		checks = 0;
		tests = 0;
		clk_div = 7;
		stroke_val = 1000;
		model_pos = 1;
		rise_count = 0;
		clk_total = 0;
		first_rise_clk = 0;
		prof_on = 1'b0;
		prof_n = 0;
		acce_max_v = 5;
		deac_max_v = 4;
		cmd_speed = 2;
		for (i = 0; i < 16; i++) begin
			acce_tbl[i] = 0;
			deac_tbl[i] = 0;
		end
		repeat (5) @(posedge clk);
		resetn <= 1'b1;
		repeat (2) @(posedge clk);

		begin_test();
		write_readback(REG_SPEED, cmd_speed);
		write_readback(REG_STEPS, 32'd12);
		write_readback(REG_STROKE, stroke_val);
		write_readback(REG_TABLE_MAX, {16'(deac_max_v), 16'(acce_max_v)});
		write_readback(REG_CLKDIV, 32'd11);
		reg_write(REG_CLKDIV, clk_div);
		axi_write(12'h030, 32'h5a5a, resp);
		check_eq("bresp of unmapped write", resp, 2);
		axi_read(12'h030, rd, resp);
		check_eq("rresp of unmapped read", resp, 2);
		end_test("register readback");

		begin_test();
		for (i = 0; i <= acce_max_v; i++) begin
			acce_tbl[i] = 1 + (($random(seed) & 32'h7fffffff) % 6);
			reg_write(ACCE_BASE + AXI_ADDR_W'(4 * i), acce_tbl[i]);
		end
		for (i = 0; i <= deac_max_v; i++) begin
			deac_tbl[i] = 1 + (($random(seed) & 32'h7fffffff) % 6);
			reg_write(DEAC_BASE + AXI_ADDR_W'(4 * i), deac_tbl[i]);
		end
		start_move(12, 1'b0, 3'd5, 1'b1);
		wait_idle(1'b1);
		check_eq("rising edges", rise_count, 12);
		check_eq("o_ms", ms, 5);
		reg_read(REG_STATUS, rd);
		check_eq("running bit", rd[0], 0);
		reg_read(REG_POSITION, rd);
		check_eq("position", rd, model_pos);
		end_test("ramp profile");

		begin_test();
		cmd_speed = 1;
		reg_write(REG_SPEED, cmd_speed);
		reg_read(REG_POSITION, rd);
		pos0 = rd;
		start_move(200, 1'b0, 3'd0, 1'b0);
		wait_rises(5);
		reg_write(REG_CTRL, 32'h2);
		wait_idle(1'b0);
		check_eq("drive after stop", drive, 0);
		if (rise_count >= 200) begin
			errors = errors + 1;
			$display("stop did not cut the move short");
		end
		reg_read(REG_STATUS, rd);
		check_eq("running bit after stop", rd[0], 0);
		reg_read(REG_POSITION, rd);
		check_eq("position after stop", rd, pos0 + rise_count);
		end_test("stop command");

		begin_test();
		dir0 = dir;
		start_move(6, 1'b1, 3'd2, 1'b1);
		t0 = clk_total;
		wait_idle(1'b1);
		check_eq("o_dir after reversal", dir, !dir0);
		check_eq("o_ms after reversal", ms, 2);
		check_eq("rising edges", rise_count, 6);
		checks = checks + 1;
		if ((first_rise_clk - t0) / (clk_div + 1) < REVERSE_DELAY - 1) begin
			errors = errors + 1;
			$display("Error %0t ns: first step %0d ticks after start, expected at least %0d",
				$time, (first_rise_clk - t0) / (clk_div + 1), REVERSE_DELAY - 1);
		end
		reg_read(REG_POSITION, rd);
		check_eq("position", rd, model_pos);
		end_test("reversal");

		begin_test();
		reg_read(REG_POSITION, rd);
		stroke_val = rd + 5;
		reg_write(REG_STROKE, stroke_val);
		start_move(20, 1'b0, 3'd0, 1'b1);
		wait_idle(1'b1);
		check_eq("rising edges to stroke", rise_count, 5);
		reg_read(REG_STATUS, rd);
		check_eq("terminal sign", rd[2], 1);
		reg_read(REG_POSITION, rd);
		check_eq("position at stroke", rd, stroke_val);
		start_move(60, 1'b1, 3'd0, 1'b1);
		wait_idle(1'b1);
		check_eq("rising edges to zero", rise_count, stroke_val - 1);
		reg_read(REG_STATUS, rd);
		check_eq("zero sign", rd[1], 1);
		reg_read(REG_POSITION, rd);
		check_eq("position at zero", rd, 1);
		end_test("travel limits");

		// failed assertions in the bound checker
		errors = errors +
			i_step_motor_ctrl_top.i_motor_ramp_core.i_step_motor_properties.fail_count;
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== verification/step_motor_properties.sv ====
`timescale 1ns/1ps

module step_motor_properties (
	input logic clk,
	input logic resetn,
	input logic i_tick,
	input logic i_drive,
	input logic i_dir,
	input logic i_state
);

	int fail_count = 0;

	// no step pulses outside a move
	assert property (@(posedge clk) disable iff (!resetn) !i_state |-> !i_drive)
		else begin
			$error("drive high while the core is idle");
			fail_count = fail_count + 1;
		end

	assert property (@(posedge clk) disable iff (!resetn) $past(i_state) |-> $stable(i_dir))
		else begin
			$error("direction changed during a move");
			fail_count = fail_count + 1;
		end

	// drive only moves on clock-enable cycles
	assert property (@(posedge clk) disable iff (!resetn) $changed(i_drive) |-> $past(i_tick))
		else begin
			$error("drive toggled without a tick");
			fail_count = fail_count + 1;
		end

endmodule

bind motor_ramp_core step_motor_properties i_step_motor_properties (
	.clk(clk),
	.resetn(resetn),
	.i_tick(i_tick),
	.i_drive(o_drive),
	.i_dir(o_dir),
	.i_state(o_state)
);

// ==== rtl/step_motor_ctrl_top.sv ====
`timescale 1ns/1ps

module step_motor_ctrl_top
	import step_motor_pkg::*;
#(
	parameter int SPEED_ADDR_W = 8,
	parameter int REVERSE_DELAY = 4
) (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic [AXI_ADDR_W-1:0] i_s_axil_awaddr,
	input  logic                  i_s_axil_awvalid,
	output logic                  o_s_axil_awready,
	input  logic [31:0]           i_s_axil_wdata,
	input  logic                  i_s_axil_wvalid,
	output logic                  o_s_axil_wready,
	output logic [1:0]            o_s_axil_bresp,
	output logic                  o_s_axil_bvalid,
	input  logic                  i_s_axil_bready,
	input  logic [AXI_ADDR_W-1:0] i_s_axil_araddr,
	input  logic                  i_s_axil_arvalid,
	output logic                  o_s_axil_arready,
	output logic [31:0]           o_s_axil_rdata,
	output logic [1:0]            o_s_axil_rresp,
	output logic                  o_s_axil_rvalid,
	input  logic                  i_s_axil_rready,
	input  logic                  i_zpd,
	output logic                  o_drive,
	output logic                  o_dir,
	output logic [MS_W-1:0]       o_ms
);

	logic start;
	logic stop;
	speed_t speed;
	logic [STEP_W-1:0] steps;
	logic dir;
	logic [MS_W-1:0] ms;
	logic [SPEED_ADDR_W-1:0] acce_max;
	logic [SPEED_ADDR_W-1:0] deac_max;
	logic [STEP_W-1:0] stroke;
	logic [15:0] div;
	logic tick;
	logic acce_wr_en;
	logic deac_wr_en;
	logic [SPEED_ADDR_W-1:0] tbl_addr;
	speed_t tbl_data;
	logic acce_rd_en;
	logic [SPEED_ADDR_W-1:0] acce_addr;
	speed_t acce_data;
	logic deac_rd_en;
	logic [SPEED_ADDR_W-1:0] deac_addr;
	speed_t deac_data;
	logic state;
	logic zpsign;
	logic tpsign;
	logic [STEP_W-1:0] position;
	speed_t rt_speed;

	motor_regs_axil #(
		.SPEED_ADDR_W(SPEED_ADDR_W)
	) i_motor_regs_axil (
		.clk(clk),
		.resetn(resetn),
		.i_s_axil_awaddr(i_s_axil_awaddr),
		.i_s_axil_awvalid(i_s_axil_awvalid),
		.o_s_axil_awready(o_s_axil_awready),
		.i_s_axil_wdata(i_s_axil_wdata),
		.i_s_axil_wvalid(i_s_axil_wvalid),
		.o_s_axil_wready(o_s_axil_wready),
		.o_s_axil_bresp(o_s_axil_bresp),
		.o_s_axil_bvalid(o_s_axil_bvalid),
		.i_s_axil_bready(i_s_axil_bready),
		.i_s_axil_araddr(i_s_axil_araddr),
		.i_s_axil_arvalid(i_s_axil_arvalid),
		.o_s_axil_arready(o_s_axil_arready),
		.o_s_axil_rdata(o_s_axil_rdata),
		.o_s_axil_rresp(o_s_axil_rresp),
		.o_s_axil_rvalid(o_s_axil_rvalid),
		.i_s_axil_rready(i_s_axil_rready),
		.o_start(start),
		.o_stop(stop),
		.o_speed(speed),
		.o_steps(steps),
		.o_dir(dir),
		.o_ms(ms),
		.o_acce_max(acce_max),
		.o_deac_max(deac_max),
		.o_stroke(stroke),
		.o_div(div),
		.o_acce_wr_en(acce_wr_en),
		.o_deac_wr_en(deac_wr_en),
		.o_tbl_addr(tbl_addr),
		.o_tbl_data(tbl_data),
		.i_state(state),
		.i_zpsign(zpsign),
		.i_tpsign(tpsign),
		.i_position(position),
		.i_rt_speed(rt_speed)
	);

	step_clk_divider i_step_clk_divider (
		.clk(clk),
		.resetn(resetn),
		.i_div(div),
		.o_tick(tick)
	);

	speed_table_ram #(
		.SPEED_ADDR_W(SPEED_ADDR_W)
	) i_acce_table (
		.clk(clk),
		.resetn(resetn),
		.i_wr_en(acce_wr_en),
		.i_wr_addr(tbl_addr),
		.i_wr_data(tbl_data),
		.i_rd_en(acce_rd_en),
		.i_rd_addr(acce_addr),
		.o_rd_data(acce_data)
	);

	speed_table_ram #(
		.SPEED_ADDR_W(SPEED_ADDR_W)
	) i_deac_table (
		.clk(clk),
		.resetn(resetn),
		.i_wr_en(deac_wr_en),
		.i_wr_addr(tbl_addr),
		.i_wr_data(tbl_data),
		.i_rd_en(deac_rd_en),
		.i_rd_addr(deac_addr),
		.o_rd_data(deac_data)
	);

	motor_ramp_core #(
		.SPEED_ADDR_W(SPEED_ADDR_W),
		.REVERSE_DELAY(REVERSE_DELAY)
	) i_motor_ramp_core (
		.clk(clk),
		.resetn(resetn),
		.i_tick(tick),
		.i_start(start),
		.i_stop(stop),
		.i_speed(speed),
		.i_steps(steps),
		.i_dir(dir),
		.i_ms(ms),
		.i_acce_max(acce_max),
		.i_deac_max(deac_max),
		.i_stroke(stroke),
		.i_zpd(i_zpd),
		.o_acce_rd_en(acce_rd_en),
		.o_acce_addr(acce_addr),
		.i_acce_data(acce_data),
		.o_deac_rd_en(deac_rd_en),
		.o_deac_addr(deac_addr),
		.i_deac_data(deac_data),
		.o_drive(o_drive),
		.o_dir(o_dir),
		.o_ms(o_ms),
		.o_state(state),
		.o_zpsign(zpsign),
		.o_tpsign(tpsign),
		.o_position(position),
		.o_rt_speed(rt_speed)
	);

endmodule

// ==== rtl/motor_regs_axil.sv ====
`timescale 1ns/1ps

module motor_regs_axil
	import step_motor_pkg::*;
#(
	parameter int SPEED_ADDR_W = 8
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic [AXI_ADDR_W-1:0]   i_s_axil_awaddr,
	input  logic                    i_s_axil_awvalid,
	output logic                    o_s_axil_awready,
	input  logic [31:0]             i_s_axil_wdata,
	input  logic                    i_s_axil_wvalid,
	output logic                    o_s_axil_wready,
	output logic [1:0]              o_s_axil_bresp,
	output logic                    o_s_axil_bvalid,
	input  logic                    i_s_axil_bready,
	input  logic [AXI_ADDR_W-1:0]   i_s_axil_araddr,
	input  logic                    i_s_axil_arvalid,
	output logic                    o_s_axil_arready,
	output logic [31:0]             o_s_axil_rdata,
	output logic [1:0]              o_s_axil_rresp,
	output logic                    o_s_axil_rvalid,
	input  logic                    i_s_axil_rready,
	output logic                    o_start,
	output logic                    o_stop,
	output speed_t                  o_speed,
	output logic [STEP_W-1:0]       o_steps,
	output logic                    o_dir,
	output logic [MS_W-1:0]         o_ms,
	output logic [SPEED_ADDR_W-1:0] o_acce_max,
	output logic [SPEED_ADDR_W-1:0] o_deac_max,
	output logic [STEP_W-1:0]       o_stroke,
	output logic [15:0]             o_div,
	output logic                    o_acce_wr_en,
	output logic                    o_deac_wr_en,
	output logic [SPEED_ADDR_W-1:0] o_tbl_addr,
	output speed_t                  o_tbl_data,
	input  logic                    i_state,
	input  logic                    i_zpsign,
	input  logic                    i_tpsign,
	input  logic [STEP_W-1:0]       i_position,
	input  speed_t                  i_rt_speed
);

	localparam int TBL_BYTES = 4 << SPEED_ADDR_W;
	localparam logic [1:0] RESP_OKAY = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	logic wr_go;
	logic rd_go;
	logic wr_acce;
	logic wr_deac;
	logic wr_ok;
	logic rd_ok;
	logic [31:0] rd_word;

	function automatic logic in_window(input logic [AXI_ADDR_W-1:0] addr,
		input logic [AXI_ADDR_W-1:0] base);
		return (int'(addr) >= int'(base)) && (int'(addr) < int'(base) + TBL_BYTES);
	endfunction

	// write needs address and data together
	assign wr_go = i_s_axil_awvalid && i_s_axil_wvalid && !o_s_axil_bvalid;
	assign o_s_axil_awready = wr_go;
	assign o_s_axil_wready = wr_go;
	assign rd_go = i_s_axil_arvalid && !o_s_axil_rvalid;
	assign o_s_axil_arready = !o_s_axil_rvalid;

	assign wr_acce = in_window(i_s_axil_awaddr, ACCE_BASE);
	assign wr_deac = in_window(i_s_axil_awaddr, DEAC_BASE);

	always_comb begin
		case (i_s_axil_awaddr)
			REG_CTRL, REG_SPEED, REG_STEPS, REG_STATUS, REG_POSITION,
			REG_RT_SPEED, REG_TABLE_MAX, REG_STROKE, REG_CLKDIV: wr_ok = 1'b1;
			default: wr_ok = wr_acce || wr_deac;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_start <= 1'b0;
			o_stop <= 1'b0;
			o_speed <= '0;
			o_steps <= '0;
			o_dir <= 1'b0;
			o_ms <= '0;
			o_acce_max <= '0;
			o_deac_max <= '0;
			o_stroke <= '1;
			o_div <= 16'd7;
		end else begin
			o_start <= 1'b0;
			o_stop <= 1'b0;
			if (wr_go) begin
				case (i_s_axil_awaddr)
					REG_CTRL: begin
						o_start <= i_s_axil_wdata[0];
						o_stop <= i_s_axil_wdata[1];
						o_dir <= i_s_axil_wdata[2];
						o_ms <= i_s_axil_wdata[4 +: MS_W];
					end
					REG_SPEED: o_speed <= i_s_axil_wdata[SPEED_W-1:0];
					REG_STEPS: o_steps <= i_s_axil_wdata[STEP_W-1:0];
					REG_TABLE_MAX: begin
						o_acce_max <= i_s_axil_wdata[SPEED_ADDR_W-1:0];
						o_deac_max <= i_s_axil_wdata[16 +: SPEED_ADDR_W];
					end
					REG_STROKE: o_stroke <= i_s_axil_wdata[STEP_W-1:0];
					REG_CLKDIV: o_div <= i_s_axil_wdata[15:0];
					default: ;
				endcase
			end
		end
	end

	// table window writes
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_acce_wr_en <= 1'b0;
			o_deac_wr_en <= 1'b0;
		end else begin
			o_acce_wr_en <= wr_go && wr_acce;
			o_deac_wr_en <= wr_go && wr_deac;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_go) begin
			o_tbl_addr <= i_s_axil_awaddr[2 +: SPEED_ADDR_W];
			o_tbl_data <= i_s_axil_wdata[SPEED_W-1:0];
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_s_axil_bvalid <= 1'b0;
		else if (wr_go)
			o_s_axil_bvalid <= 1'b1;
		else if (i_s_axil_bready)
			o_s_axil_bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_go)
			o_s_axil_bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
	end

	// read mux, table windows read as zero
	always_comb begin
		rd_word = '0;
		rd_ok = 1'b1;
		case (i_s_axil_araddr)
			REG_CTRL: begin
				rd_word[2] = o_dir;
				rd_word[4 +: MS_W] = o_ms;
			end
			REG_SPEED: rd_word[SPEED_W-1:0] = o_speed;
			REG_STEPS: rd_word[STEP_W-1:0] = o_steps;
			REG_STATUS: rd_word[2:0] = {i_tpsign, i_zpsign, i_state};
			REG_POSITION: rd_word[STEP_W-1:0] = i_position;
			REG_RT_SPEED: rd_word[SPEED_W-1:0] = i_rt_speed;
			REG_TABLE_MAX: begin
				rd_word[SPEED_ADDR_W-1:0] = o_acce_max;
				rd_word[16 +: SPEED_ADDR_W] = o_deac_max;
			end
			REG_STROKE: rd_word[STEP_W-1:0] = o_stroke;
			REG_CLKDIV: rd_word[15:0] = o_div;
			default: begin
				rd_ok = in_window(i_s_axil_araddr, ACCE_BASE) ||
					in_window(i_s_axil_araddr, DEAC_BASE);
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_s_axil_rvalid <= 1'b0;
		else if (rd_go)
			o_s_axil_rvalid <= 1'b1;
		else if (i_s_axil_rready)
			o_s_axil_rvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (rd_go) begin
			o_s_axil_rdata <= rd_word;
			o_s_axil_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

endmodule

// ==== rtl/motor_ramp_core.sv ====
`timescale 1ns/1ps

module motor_ramp_core
	import step_motor_pkg::*;
#(
	parameter int SPEED_ADDR_W = 8,
	parameter int REVERSE_DELAY = 4
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    i_tick,
	input  logic                    i_start,
	input  logic                    i_stop,
	input  speed_t                  i_speed,
	input  logic [STEP_W-1:0]       i_steps,
	input  logic                    i_dir,
	input  logic [MS_W-1:0]         i_ms,
	input  logic [SPEED_ADDR_W-1:0] i_acce_max,
	input  logic [SPEED_ADDR_W-1:0] i_deac_max,
	input  logic [STEP_W-1:0]       i_stroke,
	input  logic                    i_zpd,
	output logic                    o_acce_rd_en,
	output logic [SPEED_ADDR_W-1:0] o_acce_addr,
	input  speed_t                  i_acce_data,
	output logic                    o_deac_rd_en,
	output logic [SPEED_ADDR_W-1:0] o_deac_addr,
	input  speed_t                  i_deac_data,
	output logic                    o_drive,
	output logic                    o_dir,
	output logic [MS_W-1:0]         o_ms,
	output logic                    o_state,
	output logic                    o_zpsign,
	output logic                    o_tpsign,
	output logic [STEP_W-1:0]       o_position,
	output speed_t                  o_rt_speed
);

	localparam logic [1:0] IDLE = 2'b00;
	localparam logic [1:0] PREPARE = 2'b10;
	localparam logic [1:0] RUNNING = 2'b11;
	localparam int RD_W = $clog2(REVERSE_DELAY);

	logic [1:0] state;
	logic start_pend;
	logic stop_pend;
	speed_t req_speed;
	logic [STEP_W-1:0] req_steps;
	logic req_dir;
	logic [MS_W-1:0] req_ms;
	speed_t speed_max;
	speed_t speed_var;
	speed_t speed_cur;
	speed_t speed_cnt;
	logic [STEP_W-1:0] step_cnt;
	logic [STEP_W-1:0] step_remain;
	logic step_done;
	logic [RD_W-1:0] rev_cnt;
	logic [4:0] rd_pipe;
	logic acce_ing;
	logic deac_ing;
	logic drive_d1;
	logic forward;
	logic should_start;
	logic half_done;
	logic step_fall;
	logic run_end;

	assign o_state = state[1];
	assign o_rt_speed = speed_cur;
	assign forward = ~o_dir;
	assign should_start = i_tick && start_pend && !o_state;
	assign half_done = (speed_cnt == '0);
	assign step_fall = i_tick && (state == RUNNING) && half_done && o_drive;
	// end of move, stop command or either end of travel
	assign run_end = stop_pend || (step_done && half_done) ||
		(o_tpsign && forward) || (o_zpsign && !forward);

	always_ff @(posedge clk) begin
		if (!resetn)
			start_pend <= 1'b0;
		else if (start_pend) begin
			if (i_tick)
				start_pend <= 1'b0;
		end else if (i_start && !o_state)
			start_pend <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (i_start && !start_pend && !o_state) begin
			req_speed <= i_speed;
			req_steps <= i_steps;
			req_dir <= i_dir;
			req_ms <= i_ms;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			stop_pend <= 1'b0;
		else if (stop_pend) begin
			if (i_tick)
				stop_pend <= 1'b0;
		end else if (i_stop && o_state)
			stop_pend <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= IDLE;
		end else if (i_tick) begin
			case (state)
				IDLE: begin
					if (start_pend)
						state <= (o_dir == req_dir) ? RUNNING : PREPARE;
				end
				PREPARE: begin
					if (stop_pend)
						state <= IDLE;
					else if (rev_cnt == RD_W'(REVERSE_DELAY - 2))
						state <= RUNNING;
				end
				RUNNING: begin
					if (run_end)
						state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// reverse delay
	always_ff @(posedge clk) begin
		if (!resetn)
			rev_cnt <= '0;
		else if (i_tick)
			rev_cnt <= (state == PREPARE) ? rev_cnt + 1'b1 : '0;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_dir <= 1'b0;
			o_ms <= '0;
		end else if (should_start) begin
			o_dir <= req_dir;
			o_ms <= req_ms;
		end
	end

	always_ff @(posedge clk) begin
		if (should_start)
			speed_max <= req_speed;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			step_cnt <= '0;
			step_remain <= '0;
		end else if (should_start) begin
			step_cnt <= '0;
			step_remain <= req_steps - 1'b1;
		end else if (step_fall) begin
			step_cnt <= step_cnt + 1'b1;
			step_remain <= step_remain - 1'b1;
		end
	end

	// set on the last falling edge, the low level still runs out
	always_ff @(posedge clk) begin
		if (!resetn)
			step_done <= 1'b0;
		else if (i_tick) begin
			if (state != RUNNING)
				step_done <= 1'b0;
			else if (half_done && o_drive && step_remain == '0)
				step_done <= 1'b1;
		end
	end

	// lookup pipeline: clamp, address, read, compare, select
	always_ff @(posedge clk) begin
		if (!resetn)
			rd_pipe <= '0;
		else
			rd_pipe <= {rd_pipe[3:0], should_start || step_fall};
	end

	assign o_acce_rd_en = rd_pipe[2];
	assign o_deac_rd_en = rd_pipe[2];

	always_ff @(posedge clk) begin
		if (rd_pipe[0]) begin
			acce_ing <= (step_cnt < STEP_W'(i_acce_max));
			deac_ing <= (step_remain < STEP_W'(i_deac_max));
		end
		if (rd_pipe[1]) begin
			o_acce_addr <= acce_ing ? step_cnt[SPEED_ADDR_W-1:0] : i_acce_max;
			o_deac_addr <= deac_ing ? step_remain[SPEED_ADDR_W-1:0] : i_deac_max;
		end
		if (rd_pipe[3])
			speed_var <= (i_acce_data > i_deac_data) ? i_acce_data : i_deac_data;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			speed_cur <= '0;
		else if (rd_pipe[4])
			speed_cur <= (speed_var > speed_max) ? speed_var : speed_max;
	end

	// half-period counter and drive
	always_ff @(posedge clk) begin
		if (!resetn) begin
			speed_cnt <= '0;
			o_drive <= 1'b0;
		end else if (i_tick) begin
			if (state != RUNNING || run_end) begin
				speed_cnt <= '0;
				o_drive <= 1'b0;
			end else if (half_done) begin
				speed_cnt <= speed_cur;
				if (!step_done)
					o_drive <= ~o_drive;
			end else begin
				speed_cnt <= speed_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			drive_d1 <= 1'b0;
		else
			drive_d1 <= o_drive;
	end

	always_ff @(posedge clk) begin
		if (!resetn)
			o_zpsign <= 1'b0;
		else if (i_zpd)
			o_zpsign <= 1'b1;
		else if (state == RUNNING && forward)
			o_zpsign <= 1'b0;
	end

	// position moves on each completed step
	always_ff @(posedge clk) begin
		if (!resetn) begin
			o_position <= STEP_W'(1);
		end else if (o_zpsign) begin
			o_position <= STEP_W'(1);
		end else if (drive_d1 && !o_drive) begin
			if (forward) begin
				if (o_position < i_stroke)
					o_position <= o_position + 1'b1;
			end else if (o_position > STEP_W'(1)) begin
				o_position <= o_position - 1'b1;
			end
		end
	end

	assign o_tpsign = (o_position == i_stroke);

endmodule

// ==== rtl/step_clk_divider.sv ====
`timescale 1ns/1ps

module step_clk_divider (
	input  logic        clk,
	input  logic        resetn,
	input  logic [15:0] i_div,
	output logic        o_tick
);

	logic [15:0] cnt;

	// one tick per i_div+1 clocks, new divide count applies at reload
	always_ff @(posedge clk) begin
		if (!resetn) begin
			cnt <= '0;
			o_tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt <= i_div;
			o_tick <= 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
			o_tick <= 1'b0;
		end
	end

endmodule

// ==== rtl/speed_table_ram.sv ====
`timescale 1ns/1ps

module speed_table_ram
	import step_motor_pkg::*;
#(
	parameter int SPEED_ADDR_W = 8
) (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    i_wr_en,
	input  logic [SPEED_ADDR_W-1:0] i_wr_addr,
	input  speed_t                  i_wr_data,
	input  logic                    i_rd_en,
	input  logic [SPEED_ADDR_W-1:0] i_rd_addr,
	output speed_t                  o_rd_data
);

	speed_t mem [0:(1 << SPEED_ADDR_W) - 1];

	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr] <= i_wr_data;
	end

	// output register, one clock after the read enable
	always_ff @(posedge clk) begin
		if (!resetn)
			o_rd_data <= '0;
		else if (i_rd_en)
			o_rd_data <= mem[i_rd_addr];
	end

endmodule

// ==== rtl/step_motor_pkg.sv ====
package step_motor_pkg;

	localparam int SPEED_W = 16;
	localparam int STEP_W = 16;
	localparam int MS_W = 3;
	localparam int AXI_ADDR_W = 12;

	// half-period in clock-enable ticks
	typedef logic [SPEED_W-1:0] speed_t;

	// register map, byte addresses
	localparam logic [AXI_ADDR_W-1:0] REG_CTRL = 12'h000;
	localparam logic [AXI_ADDR_W-1:0] REG_SPEED = 12'h004;
	localparam logic [AXI_ADDR_W-1:0] REG_STEPS = 12'h008;
	localparam logic [AXI_ADDR_W-1:0] REG_STATUS = 12'h00C;
	localparam logic [AXI_ADDR_W-1:0] REG_POSITION = 12'h010;
	localparam logic [AXI_ADDR_W-1:0] REG_RT_SPEED = 12'h014;
	localparam logic [AXI_ADDR_W-1:0] REG_TABLE_MAX = 12'h018;
	localparam logic [AXI_ADDR_W-1:0] REG_STROKE = 12'h01C;
	localparam logic [AXI_ADDR_W-1:0] REG_CLKDIV = 12'h020;

	// table windows, one word per entry
	localparam logic [AXI_ADDR_W-1:0] ACCE_BASE = 12'h400;
	localparam logic [AXI_ADDR_W-1:0] DEAC_BASE = 12'h800;

endpackage
